/* flist.f */
src/video_pkg.sv
src/raster_if.sv
src/raster_counter.sv
src/sync_gen.sv
src/scan_gate.sv
src/colorbar_gen.sv
src/video_timing_top.sv
testbench/tb_video_timing.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the video timing testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_video_timing \
    -o sim_tb_video_timing

./obj_dir/sim_tb_video_timing | tee "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/tb_video_timing.sv */
`timescale 1ns/100ps

module tb_video_timing;

    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int RUN_FRAMES   = 4;
    localparam int DRAW_LINE    = 200;

    logic                        clk;
    logic                        rst;
    logic                        scan_ena;
    logic                        hsync;
    logic                        vsync;
    logic                        csync;
    logic                        hblank;
    logic                        vblank;
    logic                        framestart;
    logic                        linestart;
    logic                        pixrequest;
    logic [video_pkg::CNT_W-1:0] hcount;
    logic [video_pkg::CNT_W-1:0] vcount;
    logic [7:0]                  bar_r;
    logic [7:0]                  bar_g;
    logic [7:0]                  bar_b;

    logic [31:0] rand_state;
    int          exp_h;
    int          exp_v;
    logic        next_ena;
    logic        model_ena;
    int          frames_done;
    int          enabled_frames;

    video_timing_top i_video_timing_top (
        .clk        (clk),
        .rst        (rst),
        .scan_ena   (scan_ena),
        .hsync      (hsync),
        .vsync      (vsync),
        .csync      (csync),
        .hblank     (hblank),
        .vblank     (vblank),
        .framestart (framestart),
        .linestart  (linestart),
        .pixrequest (pixrequest),
        .hcount     (hcount),
        .vcount     (vcount),
        .bar_r      (bar_r),
        .bar_g      (bar_g),
        .bar_b      (bar_b)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 75 % bars as {r, g, b}, left to right
    function automatic logic [23:0] bar_color(input int idx);
        case (idx)
            0: return 24'hBFBFBF;
            1: return 24'hBFBF00;
            2: return 24'h00BFBF;
            3: return 24'h00BF00;
            4: return 24'hBF00BF;
            5: return 24'hBF0000;
            6: return 24'h0000BF;
            default: return 24'h000000;
        endcase
    endfunction

    function automatic int bar_index(input int p);
        int idx;
        idx = 0;
        for (int k = 1; k < 7; k++) begin
            if ((k * video_pkg::H_ACTIVE) / 7 <= p) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%h, expected 0x%h at h=%0d v=%0d",
                     name, actual, expected, exp_h, exp_v);
            abort_run();
        end
    endtask

    // One clock: advance the position model, track the frame enable, drive scan_ena
    task automatic step_cycle();
        @(negedge clk);
        if (exp_h == video_pkg::H_TOTAL - 1) begin
            exp_h = 0;
            exp_v = (exp_v == video_pkg::V_TOTAL - 1) ? 0 : exp_v + 1;
        end else begin
            exp_h++;
        end
        check_value("hcount", 32'(hcount), 32'(exp_h));
        check_value("vcount", 32'(vcount), 32'(exp_v));
        if (exp_h == 0 && exp_v == 0) begin
            model_ena = next_ena;
            if (model_ena) begin
                enabled_frames++;
            end
        end
        // Enable held at frame end governs the next frame
        if (exp_h == video_pkg::H_TOTAL - 1 && exp_v == video_pkg::V_TOTAL - 1) begin
            next_ena = scan_ena;
        end
        if (exp_h == 0 && exp_v == DRAW_LINE) begin
            rand_state = lcg_next(rand_state);
            scan_ena = rand_state[31];
        end
    endtask

    task automatic check_outputs();
        int          h;
        int          v;
        int          p;
        logic        h_act;
        logic        v_act;
        logic        req;
        logic        exp_csync;
        logic [23:0] exp_rgb;
        h = int'(hcount);
        v = int'(vcount);
        p = h - video_pkg::REQ_START;
        h_act = (h >= video_pkg::H_ACT_START) &&
                (h < video_pkg::H_ACT_START + video_pkg::H_ACTIVE);
        v_act = (v >= video_pkg::V_ACT_START) &&
                (v < video_pkg::V_ACT_START + video_pkg::V_ACTIVE);
        req = v_act && (p >= 0) && (p < video_pkg::H_ACTIVE);
        // Serrated sync on vsync lines
        if (v < video_pkg::V_SYNC) begin
            exp_csync = (h <= video_pkg::H_TOTAL - video_pkg::H_SYNC);
        end else begin
            exp_csync = (h < video_pkg::H_SYNC);
        end
        exp_rgb = req ? bar_color(bar_index(p)) : 24'h000000;
        check_value("hsync", 32'(hsync), 32'(h < video_pkg::H_SYNC));
        check_value("vsync", 32'(vsync), 32'(v < video_pkg::V_SYNC));
        check_value("csync", 32'(csync), 32'(exp_csync));
        check_value("hblank", 32'(hblank), 32'(!h_act));
        check_value("vblank", 32'(vblank), 32'(!v_act));
        check_value("framestart", 32'(framestart),
                    32'(h == 0 && v == video_pkg::FRAME_TOP));
        check_value("linestart", 32'(linestart), 32'(h == 0 && v_act && model_ena));
        check_value("pixrequest", 32'(pixrequest), 32'(req && model_ena));
        check_value("bar_r", 32'(bar_r), 32'(exp_rgb[23:16]));
        check_value("bar_g", 32'(bar_g), 32'(exp_rgb[15:8]));
        check_value("bar_b", 32'(bar_b), 32'(exp_rgb[7:0]));
    endtask

    initial begin
        int cycles;
        clk            = 1'b0;
        rst            = 1'b1;
        scan_ena       = 1'b0;
        rand_state     = 32'h9e969f91;
        exp_h          = 0;
        exp_v          = 0;
        next_ena       = 1'b0;
        model_ena      = 1'b0;
        frames_done    = 0;
        enabled_frames = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("hcount", 32'(hcount), 32'h0);
        check_value("vcount", 32'(vcount), 32'h0);
        check_value("hsync", 32'(hsync), 32'h0);
        check_value("vsync", 32'(vsync), 32'h0);
        check_value("csync", 32'(csync), 32'h0);
        check_value("pixrequest", 32'(pixrequest), 32'h0);
        check_value("hblank", 32'(hblank), 32'h1);
        check_value("vblank", 32'(vblank), 32'h1);
        rst = 1'b0;

        // Flags settle over the first frame
        step_cycle();
        cycles = 1;
        while (!(exp_h == 0 && exp_v == 0)) begin
            if (cycles > FRAME_CYCLES + 10) begin
                $display("Timed out waiting for the first frame wrap");
                abort_run();
            end
            step_cycle();
            cycles++;
        end

        check_outputs();
        cycles = 0;
        while (frames_done < RUN_FRAMES) begin
            if (cycles > RUN_FRAMES * FRAME_CYCLES + 10) begin
                $display("Timed out before %0d frames were checked", RUN_FRAMES);
                abort_run();
            end
            step_cycle();
            check_outputs();
            cycles++;
            if (exp_h == video_pkg::H_TOTAL - 1 && exp_v == video_pkg::V_TOTAL - 1) begin
                frames_done++;
            end
        end

        // Both enabled and disabled frames must have been seen
        if (enabled_frames == 0 || enabled_frames == frames_done) begin
            $display("Scan enable was the same in all %0d checked frames", frames_done);
            abort_run();
        end else begin
            $display("Checked %0d frames, %0d with scan enabled", frames_done,
                     enabled_frames);
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* src/video_timing_top.sv */
`timescale 1ns/100ps

module video_timing_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        scan_ena,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        csync,
    output logic                        hblank,
    output logic                        vblank,
    output logic                        framestart,
    output logic                        linestart,
    output logic                        pixrequest,
    output logic [video_pkg::CNT_W-1:0] hcount,
    output logic [video_pkg::CNT_W-1:0] vcount,
    output logic [7:0]                  bar_r,
    output logic [7:0]                  bar_g,
    output logic [7:0]                  bar_b
);

    raster_if i_ras (
        .clk (clk)
    );

    raster_counter i_raster_counter (
        .clk (clk),
        .rst (rst),
        .ras (i_ras.counter)
    );

    sync_gen i_sync_gen (
        .clk   (clk),
        .rst   (rst),
        .ras   (i_ras.timing),
        .csync (csync)
    );

    scan_gate i_scan_gate (
        .clk        (clk),
        .rst        (rst),
        .scan_ena   (scan_ena),
        .ras        (i_ras.consumer),
        .framestart (framestart),
        .linestart  (linestart),
        .pixrequest (pixrequest)
    );

    colorbar_gen i_colorbar_gen (
        .clk   (clk),
        .rst   (rst),
        .ras   (i_ras.consumer),
        .bar_r (bar_r),
        .bar_g (bar_g),
        .bar_b (bar_b)
    );

    assign hcount = i_ras.hcount;
    assign vcount = i_ras.vcount;
    assign hsync  = i_ras.hsync;
    assign vsync  = i_ras.vsync;
    assign hblank = i_ras.hblank;
    assign vblank = i_ras.vblank;

endmodule

/* src/colorbar_gen.sv */
`timescale 1ns/100ps

module colorbar_gen (
    input  logic        clk,
    input  logic        rst,
    raster_if.consumer  ras,
    output logic [7:0]  bar_r,
    output logic [7:0]  bar_g,
    output logic [7:0]  bar_b
);

    video_pkg::bar_state_e bar_state;
    video_pkg::pixel_t     bar_rgb;

    // Each state waits for its edge, then loads the next colour
    always_ff @(posedge clk) begin
        if (rst) begin
            bar_state <= video_pkg::LEFT_BAND;
            bar_rgb   <= '0;
        end else begin
            case (bar_state)
                video_pkg::LEFT_BAND: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_0) begin
                        bar_state <= video_pkg::BAR_WHITE;
                        bar_rgb   <= video_pkg::COLOR_75_WHITE;
                    end
                end
                video_pkg::BAR_WHITE: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_1) begin
                        bar_state <= video_pkg::BAR_YELLOW;
                        bar_rgb   <= video_pkg::COLOR_75_YELLOW;
                    end
                end
                video_pkg::BAR_YELLOW: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_2) begin
                        bar_state <= video_pkg::BAR_CYAN;
                        bar_rgb   <= video_pkg::COLOR_75_CYAN;
                    end
                end
                video_pkg::BAR_CYAN: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_3) begin
                        bar_state <= video_pkg::BAR_GREEN;
                        bar_rgb   <= video_pkg::COLOR_75_GREEN;
                    end
                end
                video_pkg::BAR_GREEN: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_4) begin
                        bar_state <= video_pkg::BAR_MAGENTA;
                        bar_rgb   <= video_pkg::COLOR_75_MAGENTA;
                    end
                end
                video_pkg::BAR_MAGENTA: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_5) begin
                        bar_state <= video_pkg::BAR_RED;
                        bar_rgb   <= video_pkg::COLOR_75_RED;
                    end
                end
                video_pkg::BAR_RED: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_6) begin
                        bar_state <= video_pkg::BAR_BLUE;
                        bar_rgb   <= video_pkg::COLOR_75_BLUE;
                    end
                end
                video_pkg::BAR_BLUE: begin
                    if (ras.hcount == video_pkg::BAR_EDGE_7) begin
                        bar_state <= video_pkg::RIGHT_BAND;
                        bar_rgb   <= '0;
                    end
                end
                video_pkg::RIGHT_BAND: begin
                    if (ras.hcount == video_pkg::BAR_RIGHT_END) begin
                        bar_state <= video_pkg::LEFT_BAND;
                    end
                end
                default: bar_state <= video_pkg::LEFT_BAND;
            endcase
        end
    end

    assign bar_r = ras.request ? bar_rgb.r : 8'h00;
    assign bar_g = ras.request ? bar_rgb.g : 8'h00;
    assign bar_b = ras.request ? bar_rgb.b : 8'h00;

    // Every bar colour is non-black, so output and request must agree
    a_bar_follows_request: assert property (
        @(posedge clk) disable iff (rst)
        (({bar_r, bar_g, bar_b} != 24'h0) == ras.request)
    );

endmodule

/* src/scan_gate.sv */
`timescale 1ns/100ps

module scan_gate (
    input  logic        clk,
    input  logic        rst,
    input  logic        scan_ena,
    raster_if.consumer  ras,
    output logic        framestart,
    output logic        linestart,
    output logic        pixrequest
);

    logic scan_in;
    logic hs_old;
    logic vs_old;
    logic frame_ena;
    logic hsync_rise;
    logic vsync_rise;

    assign hsync_rise = ras.hsync && !hs_old;
    assign vsync_rise = ras.vsync && !vs_old;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_in   <= 1'b0;
            hs_old    <= 1'b0;
            vs_old    <= 1'b0;
            frame_ena <= 1'b0;
        end else begin
            scan_in <= scan_ena;
            hs_old  <= ras.hsync;
            vs_old  <= ras.vsync;
            // New enable takes hold only at the top of a frame
            if (vsync_rise) begin
                frame_ena <= scan_in;
            end
        end
    end

    assign framestart = (ras.hcount == 0) && (ras.vcount == video_pkg::FRAME_TOP);
    assign linestart  = hsync_rise && !ras.vblank && frame_ena;
    assign pixrequest = ras.request && frame_ena;

    // Vsync rise is expected on the first pixel of the frame
    a_enable_at_frame_top: assert property (
        @(posedge clk) disable iff (rst)
        $changed(frame_ena) |-> $past(vsync_rise && (ras.hcount == 0) &&
                                      (ras.vcount == 0))
    );

endmodule

/* src/sync_gen.sv */
`timescale 1ns/100ps

module sync_gen (
    input  logic      clk,
    input  logic      rst,
    raster_if.timing  ras,
    output logic      csync
);

    logic line_end;
    logic frame_end;

    assign line_end  = (ras.hcount == video_pkg::H_TOTAL - 1);
    assign frame_end = (ras.vcount == video_pkg::V_TOTAL - 1);

    // Flags are set and cleared one count ahead so they line up with the position
    always_ff @(posedge clk) begin
        if (rst) begin
            ras.hsync   <= 1'b0;
            ras.vsync   <= 1'b0;
            csync       <= 1'b0;
            ras.hblank  <= 1'b1;
            ras.vblank  <= 1'b1;
            ras.request <= 1'b0;
        end else begin
            if (line_end) begin
                ras.hsync <= 1'b1;
            end else if (ras.hcount == video_pkg::H_SYNC - 1) begin
                ras.hsync <= 1'b0;
            end

            // Serrated composite sync on the vsync lines
            if (line_end) begin
                csync <= 1'b1;
            end else if ((!ras.vsync && ras.hcount == video_pkg::H_SYNC - 1) ||
                         (ras.vsync &&
                          ras.hcount == video_pkg::H_TOTAL - video_pkg::H_SYNC)) begin
                csync <= 1'b0;
            end

            if (ras.hcount == video_pkg::H_ACT_START - 1) begin
                ras.hblank <= 1'b0;
            end else if (ras.hcount ==
                         video_pkg::H_ACT_START + video_pkg::H_ACTIVE - 1) begin
                ras.hblank <= 1'b1;
            end

            // Vertical flags only move at the line wrap
            if (line_end) begin
                if (frame_end) begin
                    ras.vsync <= 1'b1;
                end else if (ras.vcount == video_pkg::V_SYNC - 1) begin
                    ras.vsync <= 1'b0;
                end

                if (ras.vcount == video_pkg::V_ACT_START - 1) begin
                    ras.vblank <= 1'b0;
                end else if (ras.vcount ==
                             video_pkg::V_ACT_START + video_pkg::V_ACTIVE - 1) begin
                    ras.vblank <= 1'b1;
                end
            end

            // Request runs EARLY_REQ pixels ahead of the active area
            if (!ras.vblank) begin
                if (ras.hcount == video_pkg::REQ_START - 1) begin
                    ras.request <= 1'b1;
                end else if (ras.hcount ==
                             video_pkg::REQ_START + video_pkg::H_ACTIVE - 1) begin
                    ras.request <= 1'b0;
                end
            end
        end
    end

    a_request_in_active_lines: assert property (
        @(posedge clk) disable iff (rst)
        ras.request |-> !ras.vblank
    );

    a_hsync_outside_active: assert property (
        @(posedge clk) disable iff (rst)
        !(ras.hsync && !ras.hblank)
    );

    // Vertical edges fall on the first pixel of a line
    a_vsync_at_line_start: assert property (
        @(posedge clk) disable iff (rst)
        $changed(ras.vsync) |-> (ras.hcount == 0)
    );

endmodule

/* src/raster_counter.sv */
`timescale 1ns/100ps

module raster_counter (
    input logic        clk,
    input logic        rst,
    raster_if.counter  ras
);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (ras.hcount == video_pkg::H_TOTAL - 1);
    assign v_wrap = (ras.vcount == video_pkg::V_TOTAL - 1);

    // Pixel position within the line
    always_ff @(posedge clk) begin
        if (rst) begin
            ras.hcount <= '0;
        end else if (h_wrap) begin
            ras.hcount <= '0;
        end else begin
            ras.hcount <= ras.hcount + 1'b1;
        end
    end

    // Line position, steps once per line
    always_ff @(posedge clk) begin
        if (rst) begin
            ras.vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                ras.vcount <= '0;
            end else begin
                ras.vcount <= ras.vcount + 1'b1;
            end
        end
    end

endmodule

/* src/raster_if.sv */
`timescale 1ns/100ps

interface raster_if (
    input logic clk
);

    logic [video_pkg::CNT_W-1:0] hcount;
    logic [video_pkg::CNT_W-1:0] vcount;
    logic                        hsync;
    logic                        vsync;
    logic                        hblank;
    logic                        vblank;
    logic                        request;

    // Position source
    modport counter (input clk, output hcount, output vcount);

    // Timing flags follow the position
    modport timing (
        input  clk, hcount, vcount,
        output hsync, vsync, hblank, vblank, request
    );

    modport consumer (
        input clk, hcount, vcount, hsync, vsync, hblank, vblank, request
    );

endinterface

/* src/video_pkg.sv */
package video_pkg;

    // 640x480 horizontal timing in pixels
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;

    // Vertical timing in lines
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;

    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

    localparam int CNT_W = 11;

    // Pixel request lead and framestart line
    localparam int EARLY_REQ = 2;
    localparam int FRAME_TOP = 0;

    localparam int H_ACT_START = H_SYNC + H_BACK;
    localparam int V_ACT_START = V_SYNC + V_BACK;
    localparam int REQ_START   = H_ACT_START - EARLY_REQ;

    // Counts on which each bar transition is registered
    localparam int BAR_EDGE_0 = REQ_START - 1;
    localparam int BAR_EDGE_1 = REQ_START - 1 + (1 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_2 = REQ_START - 1 + (2 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_3 = REQ_START - 1 + (3 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_4 = REQ_START - 1 + (4 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_5 = REQ_START - 1 + (5 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_6 = REQ_START - 1 + (6 * H_ACTIVE) / 7;
    localparam int BAR_EDGE_7 = REQ_START - 1 + (7 * H_ACTIVE) / 7;
    localparam int BAR_RIGHT_END = BAR_EDGE_7 + 1;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // 75 % bars
    localparam pixel_t COLOR_75_WHITE   = '{r: 8'hBF, g: 8'hBF, b: 8'hBF};
    localparam pixel_t COLOR_75_YELLOW  = '{r: 8'hBF, g: 8'hBF, b: 8'h00};
    localparam pixel_t COLOR_75_CYAN    = '{r: 8'h00, g: 8'hBF, b: 8'hBF};
    localparam pixel_t COLOR_75_GREEN   = '{r: 8'h00, g: 8'hBF, b: 8'h00};
    localparam pixel_t COLOR_75_MAGENTA = '{r: 8'hBF, g: 8'h00, b: 8'hBF};
    localparam pixel_t COLOR_75_RED     = '{r: 8'hBF, g: 8'h00, b: 8'h00};
    localparam pixel_t COLOR_75_BLUE    = '{r: 8'h00, g: 8'h00, b: 8'hBF};

    typedef enum logic [3:0] {
        LEFT_BAND,
        BAR_WHITE,
        BAR_YELLOW,
        BAR_CYAN,
        BAR_GREEN,
        BAR_MAGENTA,
        BAR_RED,
        BAR_BLUE,
        RIGHT_BAND
    } bar_state_e;

endpackage
